//--- Makefile
TOP := nkmd_cpu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
verilog/nkmd_pkg.sv
verilog/nkmd_dcd_if.sv
verilog/nkmd_fetch_decode.sv
verilog/nkmd_regfile.sv
verilog/nkmd_operand_port.sv
verilog/nkmd_alu.sv
verilog/nkmd_cpu.sv
tb/nkmd_cpu_chk.sv
tb/nkmd_cpu_tb.sv

//--- tb/nkmd_cpu_chk.sv
`default_nettype none
`timescale 1ns/10ps

module nkmd_cpu_chk import nkmd_pkg::*; (
    input wire logic clk,
    input wire logic rst,
    input wire logic [DATA_W-1:0] p_addr_i,
    input wire logic [DATA_W-1:0] r_addr_i,
    input wire logic r_rd_i,
    input wire logic [DATA_W-1:0] c_addr_i,
    input wire logic c_rd_i
);

    // No jumps, so the PC only steps by one
    pc_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> p_addr_i == $past(p_addr_i) + 1)
        else $error("p_addr_o did not step by one");

    strobe_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({r_rd_i, c_rd_i}))
        else $error("bus read strobe is unknown");

    r_addr_known: assert property (@(posedge clk) disable iff (rst)
        r_rd_i |-> !$isunknown(r_addr_i))
        else $error("r_addr_o unknown during a read");

    c_addr_known: assert property (@(posedge clk) disable iff (rst)
        c_rd_i |-> !$isunknown(c_addr_i))
        else $error("c_addr_o unknown during a read");

endmodule

bind nkmd_cpu nkmd_cpu_chk u_chk (
    .clk(clk),
    .rst(rst),
    .p_addr_i(p_addr_o),
    .r_addr_i(r_addr_o),
    .r_rd_i(r_rd_o),
    .c_addr_i(c_addr_o),
    .c_rd_i(c_rd_o)
);

`default_nettype wire

//--- tb/nkmd_cpu_tb.sv
`default_nettype none
`timescale 1ns/10ps

module nkmd_cpu_tb import nkmd_pkg::*; ();

    localparam logic [31:0] PC_RESET = 32'h0000_0100;
    localparam logic [31:0] R_MASK = 32'h5A5A_0000;

    typedef struct packed {
        int tid;
        logic [31:0] instr;
        logic [1:0] strobes;
        logic [31:0] r_addr;
        logic [31:0] c_addr;
        regsel_t wb_sel;
        logic [31:0] wb_val;
    } row_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [31:0] p_data_i = '0;
    logic [31:0] p_addr_o;
    logic [31:0] r_data_i = '0;
    logic [31:0] r_addr_o;
    logic r_rd_o;
    logic [31:0] c_data_i = '0;
    logic [31:0] c_addr_o;
    logic c_rd_o;

    row_t rows[$];
    logic [31:0] model [16] = '{default: '0};
    logic [31:0] rng = 32'd26;
    int nrows = 0;
    int checks = 0;
    int errors = 0;
    int cur_test = 0;
    int cycles = 0;
    int limit = 0;
    int test_errs [6] = '{default: 0};
    string test_names [6] = '{"reset state", "load and read back", "ALU operations",
                              "R bus read", "C bus read", "special selectors"};

    nkmd_cpu #(
        .PC_RESET(PC_RESET)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .p_data_i(p_data_i),
        .p_addr_o(p_addr_o),
        .r_data_i(r_data_i),
        .r_addr_o(r_addr_o),
        .r_rd_o(r_rd_o),
        .c_data_i(c_data_i),
        .c_addr_o(c_addr_o),
        .c_rd_o(c_rd_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] next_imm();
        rng = xorshift(rng);
        return rng[15:0];
    endfunction

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] s,
                                              input logic [31:0] t);
        case (op)
            OP_ADD: return s + t;
            OP_SUB: return s - t;
            OP_OR: return s | t;
            OP_AND: return s & t;
            OP_XOR: return s ^ t;
            default: return 32'h0;
        endcase
    endfunction

    // Encodes one instruction and predicts its bus ports and writeback
    task automatic emit(input int tid, input regsel_t rd, input alu_op_e op, input regsel_t rs,
                        input logic imm_en, input logic [15:0] imm, input regsel_t rt,
                        input logic t_rd, input logic s_rd);
        row_t row;
        row_t old;
        logic s_rd_eff;
        logic [31:0] t_val;
        logic [31:0] s_val;
        // A result becomes visible to the fourth instruction after it
        if (rows.size() >= 4) begin
            old = rows[rows.size() - 4];
            if (old.wb_sel != REG_ZERO && old.wb_sel != REG_RA && old.wb_sel != REG_PC) begin
                model[old.wb_sel] = old.wb_val;
            end
        end
        s_rd_eff = imm_en ? 1'b0 : s_rd;
        row.tid = tid;
        row.instr = {1'b0, 2'b00, t_rd, rd, op, rs, imm_en,
                     imm_en ? imm : {4'h0, rt, 7'h0, s_rd}};
        row.strobes = {t_rd, s_rd_eff};
        row.r_addr = imm_en ? {{16{imm[15]}}, imm} : model[rt];
        row.c_addr = model[rs];
        t_val = t_rd ? (row.r_addr ^ R_MASK) : row.r_addr;
        s_val = s_rd_eff ? (row.c_addr + 32'd1000) : row.c_addr;
        row.wb_sel = rd;
        row.wb_val = alu_model(op, s_val, t_val);
        rows.push_back(row);
    endtask

    task automatic nops(input int tid, input int count);
        for (int i = 0; i < count; i++) begin
            emit(tid, REG_ZERO, OP_ADD, REG_ZERO, 1'b0, 16'h0, REG_ZERO, 1'b0, 1'b0);
        end
    endtask

    // Register value shows on both r_addr_o and c_addr_o
    task automatic readback(input int tid, input regsel_t sel);
        emit(tid, REG_ZERO, OP_ADD, sel, 1'b0, 16'h0, sel, 1'b0, 1'b0);
    endtask

    task automatic build_program();
        for (int r = 1; r < 15; r++) begin
            if (r != 11) begin
                emit(1, regsel_t'(r), OP_ADD, REG_ZERO, 1'b1, next_imm(), REG_ZERO, 1'b0, 1'b0);
            end
        end
        nops(1, 3);
        for (int r = 1; r < 15; r++) begin
            if (r != 11) begin
                readback(1, regsel_t'(r));
            end
        end
        for (int op = 0; op < 8; op++) begin
            emit(2, regsel_t'(op + 1), alu_op_e'(op), 4'd12, 1'b0, 16'h0, 4'd13, 1'b0, 1'b0);
        end
        nops(2, 3);
        for (int r = 1; r < 9; r++) begin
            readback(2, regsel_t'(r));
        end
        emit(3, 4'd9, OP_ADD, 4'd14, 1'b1, next_imm(), REG_ZERO, 1'b1, 1'b0);
        emit(3, 4'd10, OP_XOR, 4'd12, 1'b1, next_imm(), REG_ZERO, 1'b1, 1'b0);
        nops(3, 3);
        readback(3, 4'd9);
        readback(3, 4'd10);
        emit(4, 4'd2, OP_ADD, 4'd12, 1'b0, 16'h0, 4'd13, 1'b0, 1'b1);
        emit(4, 4'd3, OP_OR, 4'd14, 1'b0, 16'h0, REG_ZERO, 1'b0, 1'b1);
        emit(4, 4'd4, OP_SUB, 4'd13, 1'b0, 16'h0, 4'd12, 1'b1, 1'b1);
        nops(4, 3);
        readback(4, 4'd2);
        readback(4, 4'd3);
        readback(4, 4'd4);
        emit(5, REG_ZERO, OP_ADD, 4'd12, 1'b1, next_imm(), REG_ZERO, 1'b0, 1'b0);
        emit(5, REG_RA, OP_ADD, 4'd13, 1'b1, next_imm(), REG_ZERO, 1'b0, 1'b0);
        emit(5, REG_PC, OP_ADD, 4'd14, 1'b1, next_imm(), REG_ZERO, 1'b0, 1'b0);
        nops(5, 3);
        readback(5, REG_ZERO);
        readback(5, REG_RA);
        readback(5, REG_PC);
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs[cur_test]++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int tid);
        $display("Test %0d, %s: %s (%0d errors)", tid, test_names[tid],
                 test_errs[tid] == 0 ? "ok" : "FAILED", test_errs[tid]);
    endtask

    task automatic check_row(input int i);
        row_t row;
        row = rows[i];
        cur_test = row.tid;
        check({30'h0, r_rd_o, c_rd_o}, {30'h0, row.strobes}, $sformatf("row %0d strobes", i));
        check(r_addr_o, row.r_addr, $sformatf("row %0d r_addr_o", i));
        check(c_addr_o, row.c_addr, $sformatf("row %0d c_addr_o", i));
        if (i == nrows - 1 || rows[i + 1].tid != row.tid) begin
            report_test(row.tid);
        end
    endtask

    // Program, R and C bus models
    always @(negedge clk) begin
        logic [31:0] idx;
        idx = p_addr_o - PC_RESET;
        if (idx < 32'(nrows)) begin
            p_data_i = rows[idx].instr;
        end else begin
            p_data_i = '0;
        end
        r_data_i = r_addr_o ^ R_MASK;
        c_data_i = c_addr_o + 32'd1000;
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles = cycles + 1;
            if (cycles > limit) begin
                $display("Timeout: run did not end within %0d cycles", limit);
                $display("Regression failed");
                $finish;
            end
        end
    end

    initial begin
        build_program();
        nrows = rows.size();
        limit = nrows + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Row k is fetched in cycle k, its bus ports show in cycle k+2
        for (int k = 0; k < nrows + 2; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            if (k == 0) begin
                cur_test = 0;
                check(p_addr_o, PC_RESET, "p_addr_o after reset");
            end
            if (k < 2) begin
                check({31'h0, r_rd_o}, 32'h0, "r_rd_o after reset");
                check({31'h0, c_rd_o}, 32'h0, "c_rd_o after reset");
            end
            if (k == 1) begin
                report_test(0);
            end
            if (k >= 2) begin
                check_row(k - 2);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/nkmd_alu.sv
`default_nettype none
`timescale 1ns/10ps

module nkmd_alu import nkmd_pkg::*; (
    input wire logic clk,
    input wire logic rst,

    nkmd_dcd_if.ex dcd,

    input wire logic [DATA_W-1:0] s_val_i,
    input wire logic [DATA_W-1:0] t_val_i,

    output regsel_t wb_sel_o,
    output logic [DATA_W-1:0] wb_val_o
);

    alu_op_e op_d1;
    alu_op_e op_d2;
    regsel_t rd_d1;
    regsel_t rd_d2;
    regsel_t wb_sel_q;
    logic [DATA_W-1:0] wb_val_q;

    // Two stages to line up with the operand ports
    always_ff @(posedge clk) begin
        if (rst) begin
            op_d1 <= OP_ADD;
            op_d2 <= OP_ADD;
            rd_d1 <= REG_ZERO;
            rd_d2 <= REG_ZERO;
        end else begin
            op_d1 <= dcd.op;
            op_d2 <= op_d1;
            rd_d1 <= dcd.rdsel;
            rd_d2 <= rd_d1;
        end
    end

    always_ff @(posedge clk) begin
        case (op_d2)
            OP_ADD: wb_val_q <= s_val_i + t_val_i;
            OP_SUB: wb_val_q <= s_val_i - t_val_i;
            OP_OR: wb_val_q <= s_val_i | t_val_i;
            OP_AND: wb_val_q <= s_val_i & t_val_i;
            OP_XOR: wb_val_q <= s_val_i ^ t_val_i;
            // Clamp and multiply not implemented
            default: wb_val_q <= '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_sel_q <= REG_ZERO;
        end else begin
            wb_sel_q <= rd_d2;
        end
    end

    assign wb_sel_o = wb_sel_q;
    assign wb_val_o = wb_val_q;

endmodule

`default_nettype wire

//--- verilog/nkmd_cpu.sv
`default_nettype none
`timescale 1ns/10ps

module nkmd_cpu import nkmd_pkg::*; #(
    parameter logic [DATA_W-1:0] PC_RESET = '0
) (
    input wire logic clk,
    input wire logic rst,

    // Program bus
    input wire logic [DATA_W-1:0] p_data_i,
    output logic [DATA_W-1:0] p_addr_o,

    // R bus, feeds the t operand
    input wire logic [DATA_W-1:0] r_data_i,
    output logic [DATA_W-1:0] r_addr_o,
    output logic r_rd_o,

    // C bus, feeds the s operand
    input wire logic [DATA_W-1:0] c_data_i,
    output logic [DATA_W-1:0] c_addr_o,
    output logic c_rd_o
);

    logic [DATA_W-1:0] t_addr;
    logic [DATA_W-1:0] s_addr;
    logic t_rd_en;
    logic s_rd_en;
    logic [DATA_W-1:0] t_val;
    logic [DATA_W-1:0] s_val;
    regsel_t wb_sel;
    logic [DATA_W-1:0] wb_val;

    nkmd_dcd_if u_dcd_if ();

    nkmd_fetch_decode #(
        .PC_RESET(PC_RESET)
    ) u_fetch_decode (
        .clk(clk),
        .rst(rst),
        .p_data_i(p_data_i),
        .p_addr_o(p_addr_o),
        .dcd(u_dcd_if.dcd)
    );

    nkmd_regfile u_regfile (
        .clk(clk),
        .rst(rst),
        .dcd(u_dcd_if.rf),
        .wb_sel_i(wb_sel),
        .wb_val_i(wb_val),
        .t_addr_o(t_addr),
        .s_addr_o(s_addr),
        .t_rd_en_o(t_rd_en),
        .s_rd_en_o(s_rd_en)
    );

    nkmd_operand_port u_r_port (
        .clk(clk),
        .rst(rst),
        .addr_i(t_addr),
        .rd_en_i(t_rd_en),
        .bus_data_i(r_data_i),
        .bus_addr_o(r_addr_o),
        .bus_rd_o(r_rd_o),
        .val_o(t_val)
    );

    nkmd_operand_port u_c_port (
        .clk(clk),
        .rst(rst),
        .addr_i(s_addr),
        .rd_en_i(s_rd_en),
        .bus_data_i(c_data_i),
        .bus_addr_o(c_addr_o),
        .bus_rd_o(c_rd_o),
        .val_o(s_val)
    );

    nkmd_alu u_alu (
        .clk(clk),
        .rst(rst),
        .dcd(u_dcd_if.ex),
        .s_val_i(s_val),
        .t_val_i(t_val),
        .wb_sel_o(wb_sel),
        .wb_val_o(wb_val)
    );

endmodule

`default_nettype wire

//--- verilog/nkmd_dcd_if.sv
`default_nettype none
`timescale 1ns/10ps

interface nkmd_dcd_if import nkmd_pkg::*; ();

    regsel_t rssel;
    regsel_t rtsel;
    regsel_t rdsel;
    alu_op_e op;
    logic [DATA_W-1:0] imm;
    logic imm_en;
    logic t_rd_en;
    logic s_rd_en;

    modport dcd (
        output rssel, rtsel, rdsel, op, imm, imm_en, t_rd_en, s_rd_en
    );

    modport rf (
        input rssel, rtsel, imm, imm_en, t_rd_en, s_rd_en
    );

    modport ex (
        input op, rdsel
    );

endinterface

`default_nettype wire

//--- verilog/nkmd_fetch_decode.sv
`default_nettype none
`timescale 1ns/10ps

module nkmd_fetch_decode import nkmd_pkg::*; #(
    parameter logic [DATA_W-1:0] PC_RESET = '0
) (
    input wire logic clk,
    input wire logic rst,

    input wire logic [DATA_W-1:0] p_data_i,
    output logic [DATA_W-1:0] p_addr_o,

    nkmd_dcd_if.dcd dcd
);

    logic [DATA_W-1:0] pc_q;
    instr_t instr;
    logic [DATA_W-1:0] imm_ext;

    // No jumps, so the PC only counts
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= PC_RESET;
        end else begin
            pc_q <= pc_q + 1'b1;
        end
    end

    assign p_addr_o = pc_q;

    // Program bus answers in the same cycle
    assign instr = instr_t'(p_data_i);

    assign imm_ext = {{(DATA_W - IMM_W){instr.low.imm[IMM_W-1]}}, instr.low.imm};

    always_ff @(posedge clk) begin
        if (rst) begin
            dcd.rssel <= REG_ZERO;
            dcd.rtsel <= REG_ZERO;
            dcd.rdsel <= REG_ZERO;
            dcd.op <= OP_ADD;
            dcd.imm <= '0;
            dcd.imm_en <= 1'b0;
            dcd.t_rd_en <= 1'b0;
            dcd.s_rd_en <= 1'b0;
        end else begin
            dcd.rssel <= instr.rssel;
            dcd.rdsel <= instr.rdsel;
            dcd.op <= instr.op;
            dcd.imm_en <= instr.imm_en;
            dcd.t_rd_en <= instr.t_rd_en;
            if (instr.imm_en) begin
                dcd.imm <= imm_ext;
                dcd.rtsel <= REG_ZERO;
                dcd.s_rd_en <= 1'b0;
            end else begin
                // Register form, no immediate
                dcd.imm <= '0;
                dcd.rtsel <= instr.low.rf.rtsel;
                dcd.s_rd_en <= instr.low.rf.s_rd_en;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/nkmd_operand_port.sv
`default_nettype none
`timescale 1ns/10ps

module nkmd_operand_port import nkmd_pkg::*; (
    input wire logic clk,
    input wire logic rst,

    input wire logic [DATA_W-1:0] addr_i,
    input wire logic rd_en_i,

    input wire logic [DATA_W-1:0] bus_data_i,
    output logic [DATA_W-1:0] bus_addr_o,
    output logic bus_rd_o,

    output logic [DATA_W-1:0] val_o
);

    logic [DATA_W-1:0] val_q;

    // Strobe and address straight from the address stage
    assign bus_addr_o = addr_i;
    assign bus_rd_o = rd_en_i;

    // Bus data sampled on the strobe edge, else the address is the operand
    always_ff @(posedge clk) begin
        if (rst) begin
            val_q <= '0;
        end else if (rd_en_i) begin
            val_q <= bus_data_i;
        end else begin
            val_q <= addr_i;
        end
    end

    assign val_o = val_q;

endmodule

`default_nettype wire

//--- verilog/nkmd_pkg.sv
`default_nettype none

package nkmd_pkg;

    localparam int DATA_W = 32;
    localparam int IMM_W = 16;

    typedef logic [3:0] regsel_t;

    // Selectors that read as zero and ignore writes
    localparam regsel_t REG_ZERO = 4'h0;
    localparam regsel_t REG_RA = 4'hb;
    localparam regsel_t REG_PC = 4'hf;

    typedef enum logic [2:0] {
        OP_ADD = 3'h0,
        OP_SUB = 3'h1,
        OP_OR = 3'h2,
        OP_AND = 3'h3,
        OP_XOR = 3'h4,
        OP_RESERVED = 3'h5,
        OP_CLAMP = 3'h6,
        OP_MUL = 3'h7
    } alu_op_e;

    // Low half in register form
    typedef struct packed {
        logic [3:0] spare_hi;
        regsel_t rtsel;
        logic [6:0] spare_lo;
        logic s_rd_en;
    } reg_form_t;

    // Low half, immediate or register form depending on imm_en
    typedef union packed {
        logic [IMM_W-1:0] imm;
        reg_form_t rf;
    } instr_low_u;

    typedef struct packed {
        logic reserved;
        logic [1:0] spare;
        logic t_rd_en;
        regsel_t rdsel;
        alu_op_e op;
        regsel_t rssel;
        logic imm_en;
        instr_low_u low;
    } instr_t;

endpackage

`default_nettype wire

//--- verilog/nkmd_regfile.sv
`default_nettype none
`timescale 1ns/10ps

module nkmd_regfile import nkmd_pkg::*; (
    input wire logic clk,
    input wire logic rst,

    nkmd_dcd_if.rf dcd,

    input wire regsel_t wb_sel_i,
    input wire logic [DATA_W-1:0] wb_val_i,

    output logic [DATA_W-1:0] t_addr_o,
    output logic [DATA_W-1:0] s_addr_o,
    output logic t_rd_en_o,
    output logic s_rd_en_o
);

    logic [DATA_W-1:0] regs [16];
    logic [DATA_W-1:0] rt_val;
    logic [DATA_W-1:0] rs_val;
    logic [DATA_W-1:0] t_addr_q;
    logic [DATA_W-1:0] s_addr_q;
    logic t_rd_en_q;
    logic s_rd_en_q;

    function automatic logic is_special(input regsel_t sel);
        return (sel == REG_ZERO) || (sel == REG_RA) || (sel == REG_PC);
    endfunction

    // Writeback, special selectors dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (!is_special(wb_sel_i)) begin
            regs[wb_sel_i] <= wb_val_i;
        end
    end

    // Special entries stay at their reset value of zero
    assign rt_val = regs[dcd.rtsel];
    assign rs_val = regs[dcd.rssel];

    // Operand address stage
    always_ff @(posedge clk) begin
        t_addr_q <= dcd.imm_en ? dcd.imm : rt_val;
        s_addr_q <= rs_val;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            t_rd_en_q <= 1'b0;
            s_rd_en_q <= 1'b0;
        end else begin
            t_rd_en_q <= dcd.t_rd_en;
            s_rd_en_q <= dcd.s_rd_en;
        end
    end

    assign t_addr_o = t_addr_q;
    assign s_addr_o = s_addr_q;
    assign t_rd_en_o = t_rd_en_q;
    assign s_rd_en_o = s_rd_en_q;

endmodule

`default_nettype wire
